// ==== rtl/switch_pkg.sv ====
/*
 * shared widths, direction indices and selector codes of the tile switch
 * port word union with its flit and configuration views
 */

package switch_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////////////

  localparam int data_width = 32;
  localparam int num_in     = 5;
  localparam int num_out    = 8;
  localparam int sel_width  = 4;   // one selector per output fills the data field

  // input directions
  localparam int in_nw = 0;
  localparam int in_n  = 1;
  localparam int in_e  = 2;
  localparam int in_s  = 3;
  localparam int in_w  = 4;

  // output directions, output k owns selector bits 4k+3:4k
  localparam int out_nw = 0;
  localparam int out_n  = 1;
  localparam int out_ne = 2;
  localparam int out_e  = 3;
  localparam int out_se = 4;
  localparam int out_s  = 5;
  localparam int out_sw = 6;
  localparam int out_w  = 7;

  ////////////////////////////////////////////////////////////////////
  // selector codes, anything above sel_w is off as well
  ////////////////////////////////////////////////////////////////////

  localparam logic [sel_width-1:0] sel_off = 4'd0;
  localparam logic [sel_width-1:0] sel_nw  = 4'd1;
  localparam logic [sel_width-1:0] sel_e   = 4'd2;
  localparam logic [sel_width-1:0] sel_n   = 4'd3;
  localparam logic [sel_width-1:0] sel_s   = 4'd4;
  localparam logic [sel_width-1:0] sel_w   = 4'd5;

  // data word as it moves through the switch
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  valid;
  } flit_t;

  // same bits read as a configuration word
  typedef struct packed {
    logic [num_out-1:0][sel_width-1:0] sel;
    logic                              valid;
  } conf_view_t;

  typedef union packed {
    flit_t      flit;
    conf_view_t conf;
  } port_word_t;

  typedef logic [num_in-1:0] src_onehot_t;   // one bit per input direction

endpackage

// ==== rtl/route_config.sv ====
/*
 * configuration register loaded from the west port
 * per-output selector decode into one-hot source vectors
 */

`timescale 1ns/1ps

module route_config (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           conf_en,
  input  switch_pkg::port_word_t                         conf_word,
  output switch_pkg::src_onehot_t [switch_pkg::num_out-1:0] src
);

  logic [switch_pkg::num_out-1:0][switch_pkg::sel_width-1:0] conf_q;

  // load every edge while conf_en is high, valid bit is ignored here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      conf_q <= '0;   // all outputs off
    end else if (conf_en) begin
      conf_q <= conf_word.conf.sel;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // selector decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < switch_pkg::num_out; k++) begin
      src[k] = '0;
      case (conf_q[k])
        switch_pkg::sel_off: src[k] = '0;
        switch_pkg::sel_nw:  src[k][switch_pkg::in_nw] = 1'b1;
        switch_pkg::sel_e:   src[k][switch_pkg::in_e]  = 1'b1;
        switch_pkg::sel_n:   src[k][switch_pkg::in_n]  = 1'b1;
        switch_pkg::sel_s:   src[k][switch_pkg::in_s]  = 1'b1;
        switch_pkg::sel_w:   src[k][switch_pkg::in_w]  = 1'b1;
        default:             src[k] = '0;   // codes 6 to 15
      endcase
    end
  end

  // an output listens to one input at most, the crossbar or-mux relies on it
  for (genvar k = 0; k < switch_pkg::num_out; k++) begin : g_chk
    a_src_onehot : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(src[k])
    ) else $error("output %0d selects more than one input", k);
  end

endmodule

// ==== rtl/input_stage.sv ====
/*
 * input buffer of one direction with downstream credit counter
 * head word and send strobe toward the crossbar, upstream credit return
 */

`timescale 1ns/1ps

module input_stage #(
  parameter int buf_depth = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   conf_en,
  input  switch_pkg::port_word_t d_in,
  input  logic                   credit,   // joined credit from all sinks of this input
  output logic                   send,
  output switch_pkg::flit_t      head,
  output logic                   c_out
);

  localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
  localparam int cnt_w = $clog2(buf_depth + 1);

  logic [switch_pkg::data_width-1:0] mem [buf_depth];
  logic [ptr_w-1:0]                  wr_ptr;
  logic [ptr_w-1:0]                  rd_ptr;
  logic [cnt_w-1:0]                  fill;
  logic [cnt_w-1:0]                  cred;   // free slots downstream
  logic                              wr_en;
  logic                              push;
  logic                              full;

  ////////////////////////////////////////////////////////////////////
  // buffer
  ////////////////////////////////////////////////////////////////////

  assign wr_en = d_in.flit.valid && !conf_en;   // config words never enter
  assign full  = (fill == cnt_w'(buf_depth));
  assign push  = wr_en && !full;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= d_in.flit.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == ptr_w'(buf_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, send})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // downstream credits and send
  ////////////////////////////////////////////////////////////////////

  assign send = (fill != '0) && (cred != '0);

  assign head.data  = mem[rd_ptr];
  assign head.valid = send;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cred  <= cnt_w'(buf_depth);   // every sink starts with buf_depth slots
      c_out <= 1'b0;
    end else begin
      case ({credit, send})
        2'b10:   cred <= cred + 1'b1;
        2'b01:   cred <= cred - 1'b1;
        default: cred <= cred;        // none, or spend and refill together
      endcase
      c_out <= send;   // one pulse per word leaving the buffer
    end
  end

  // upstream may only write while holding a credit, so a slot is always free
  a_no_overrun : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !full
  ) else $error("write into full input buffer, upstream overran its credits");

  // sinks cannot return more credits than words sent to them
  a_cred_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    cred <= cnt_w'(buf_depth)
  ) else $error("downstream credit counter above buf_depth");

endmodule

// ==== rtl/crossbar.sv ====
/*
 * output muxes and output registers for eight directions
 * credit join from the sinks back to each sending input
 */

`timescale 1ns/1ps

module crossbar (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  switch_pkg::src_onehot_t [switch_pkg::num_out-1:0]  src,
  input  logic [switch_pkg::num_in-1:0]                      send,
  input  switch_pkg::flit_t [switch_pkg::num_in-1:0]         head,
  input  logic [switch_pkg::num_out-1:0]                     c_in,
  output logic [switch_pkg::num_in-1:0]                      credit,
  output switch_pkg::port_word_t [switch_pkg::num_out-1:0]   d_out
);

  logic [switch_pkg::num_out-1:0]    hit;                         // source sends this cycle
  logic [switch_pkg::data_width-1:0] pick [switch_pkg::num_out];
  logic [switch_pkg::num_in-1:0]     used;                        // selected by any output
  logic [switch_pkg::num_in-1:0]     all_ok;
  logic [switch_pkg::num_in-1:0]     head_vld;                    // valid marks of the head words

  ////////////////////////////////////////////////////////////////////
  // output muxes
  ////////////////////////////////////////////////////////////////////

  // src is one-hot so an and-or mux is enough
  always_comb begin
    for (int k = 0; k < switch_pkg::num_out; k++) begin
      hit[k]  = |(src[k] & send);
      pick[k] = '0;
      for (int i = 0; i < switch_pkg::num_in; i++) begin
        if (src[k][i]) begin
          pick[k] = pick[k] | head[i].data;
        end
      end
    end
  end

  // output registers, zero when nothing arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_out <= '0;
    end else begin
      for (int k = 0; k < switch_pkg::num_out; k++) begin
        if (hit[k]) begin
          d_out[k].flit.data  <= pick[k];
          d_out[k].flit.valid <= 1'b1;
        end else begin
          d_out[k] <= '0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // credit join
  ////////////////////////////////////////////////////////////////////

  // a multicast group returns one credit, only when every member frees a slot
  always_comb begin
    for (int i = 0; i < switch_pkg::num_in; i++) begin
      used[i]   = 1'b0;
      all_ok[i] = 1'b1;
      for (int k = 0; k < switch_pkg::num_out; k++) begin
        if (src[k][i]) begin
          used[i]   = 1'b1;
          all_ok[i] = all_ok[i] & c_in[k];
        end
      end
    end
  end

  assign credit = used & all_ok;   // unrouted inputs never get credit back

  for (genvar i = 0; i < switch_pkg::num_in; i++) begin : g_vld
    assign head_vld[i] = head[i].valid;
  end

  // a valid output must trace back to a word its selected input sent
  for (genvar k = 0; k < switch_pkg::num_out; k++) begin : g_chk
    a_valid_src : assert property (
      @(posedge clk) disable iff (!rst_n)
      d_out[k].flit.valid |-> $past(|(src[k] & head_vld))
    ) else $error("output %0d valid without a send from its source", k);
  end

endmodule

// ==== rtl/switch_top.sv ====
/*
 * tile routing switch, five input stages, configuration and crossbar
 */

`timescale 1ns/1ps

module switch_top #(
  parameter int buf_depth = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   conf_en,
  // inputs
  input  switch_pkg::port_word_t d_in_nw,
  input  switch_pkg::port_word_t d_in_n,
  input  switch_pkg::port_word_t d_in_e,
  input  switch_pkg::port_word_t d_in_s,
  input  switch_pkg::port_word_t d_in_w,
  output logic                   c_out_nw,
  output logic                   c_out_n,
  output logic                   c_out_e,
  output logic                   c_out_s,
  output logic                   c_out_w,
  // outputs
  output switch_pkg::port_word_t d_out_nw,
  output switch_pkg::port_word_t d_out_n,
  output switch_pkg::port_word_t d_out_ne,
  output switch_pkg::port_word_t d_out_e,
  output switch_pkg::port_word_t d_out_se,
  output switch_pkg::port_word_t d_out_s,
  output switch_pkg::port_word_t d_out_sw,
  output switch_pkg::port_word_t d_out_w,
  input  logic                   c_in_nw,
  input  logic                   c_in_n,
  input  logic                   c_in_ne,
  input  logic                   c_in_e,
  input  logic                   c_in_se,
  input  logic                   c_in_s,
  input  logic                   c_in_sw,
  input  logic                   c_in_w
);

  switch_pkg::port_word_t [switch_pkg::num_in-1:0]   d_in_v;
  logic [switch_pkg::num_in-1:0]                     c_out_v;
  logic [switch_pkg::num_in-1:0]                     send;
  logic [switch_pkg::num_in-1:0]                     credit;
  switch_pkg::flit_t [switch_pkg::num_in-1:0]        head;
  switch_pkg::src_onehot_t [switch_pkg::num_out-1:0] src;
  switch_pkg::port_word_t [switch_pkg::num_out-1:0]  d_out_v;
  logic [switch_pkg::num_out-1:0]                    c_in_v;

  ////////////////////////////////////////////////////////////////////
  // direction ports to indexed vectors
  ////////////////////////////////////////////////////////////////////

  assign d_in_v[switch_pkg::in_nw] = d_in_nw;
  assign d_in_v[switch_pkg::in_n]  = d_in_n;
  assign d_in_v[switch_pkg::in_e]  = d_in_e;
  assign d_in_v[switch_pkg::in_s]  = d_in_s;
  assign d_in_v[switch_pkg::in_w]  = d_in_w;

  assign c_out_nw = c_out_v[switch_pkg::in_nw];
  assign c_out_n  = c_out_v[switch_pkg::in_n];
  assign c_out_e  = c_out_v[switch_pkg::in_e];
  assign c_out_s  = c_out_v[switch_pkg::in_s];
  assign c_out_w  = c_out_v[switch_pkg::in_w];

  assign c_in_v = {c_in_w, c_in_sw, c_in_s, c_in_se, c_in_e, c_in_ne, c_in_n, c_in_nw};

  assign d_out_nw = d_out_v[switch_pkg::out_nw];
  assign d_out_n  = d_out_v[switch_pkg::out_n];
  assign d_out_ne = d_out_v[switch_pkg::out_ne];
  assign d_out_e  = d_out_v[switch_pkg::out_e];
  assign d_out_se = d_out_v[switch_pkg::out_se];
  assign d_out_s  = d_out_v[switch_pkg::out_s];
  assign d_out_sw = d_out_v[switch_pkg::out_sw];
  assign d_out_w  = d_out_v[switch_pkg::out_w];

  ////////////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////////////

  route_config route_config_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .conf_en   (conf_en),
    .conf_word (d_in_w),   // config always arrives from the west
    .src       (src)
  );

  for (genvar i = 0; i < switch_pkg::num_in; i++) begin : g_stage
    input_stage #(.buf_depth(buf_depth)) input_stage_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .conf_en (conf_en),
      .d_in    (d_in_v[i]),
      .credit  (credit[i]),
      .send    (send[i]),
      .head    (head[i]),
      .c_out   (c_out_v[i])
    );
  end

  crossbar crossbar_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .src    (src),
    .send   (send),
    .head   (head),
    .c_in   (c_in_v),
    .credit (credit),
    .d_out  (d_out_v)
  );

endmodule

// ==== tests/switch_ref.svh ====
/*
 * reference routing rules of the tile switch
 * selector decode per output, outputs fed by an input, credit join
 */

`ifndef switch_ref_svh
`define switch_ref_svh

// source input of output k, or -1 when the selector means off
function automatic int expected_source(input logic [31:0] cfg, input int k);
  logic [3:0] code;
  code = cfg[4*k +: 4];
  case (code)
    4'd1:    return 0;   // nw
    4'd2:    return 2;   // e
    4'd3:    return 1;   // n
    4'd4:    return 3;   // s
    4'd5:    return 4;   // w
    default: return -1;  // 0 and 6 to 15
  endcase
endfunction

// mask of the outputs that copy input i
function automatic logic [7:0] outputs_of(input logic [31:0] cfg, input int i);
  logic [7:0] mask;
  mask = '0;
  for (int k = 0; k < 8; k++) begin
    if (expected_source(cfg, k) == i) begin
      mask[k] = 1'b1;
    end
  end
  return mask;
endfunction

// one credit back to input i only when its whole group frees a slot
function automatic logic credit_join(input logic [31:0] cfg, input int i,
                                     input logic [7:0] c_in);
  logic [7:0] group;
  group = outputs_of(cfg, i);
  return (group != 8'd0) && ((c_in & group) == group);
endfunction

`endif

// ==== tests/switch_tb.sv ====
/*
 * testbench for the tile switch, upstream senders and sink models
 * compare process against the reference routing, watchdog and report
 */

`timescale 1ns/1ps

module switch_tb;

  localparam int buf_depth = 2;
  localparam int n_uni     = 40;
  localparam int n_multi   = 40;
  localparam int n_unr     = 12;
  localparam int n_bp      = 30;
  localparam int n_reconf  = 20;
  localparam int watchdog_cycles =
    (5 * n_uni + n_multi + 5 * n_unr + n_bp + 5 * n_reconf) * 20 + 200;

  logic clk;
  logic rst_n;
  logic conf_en;
  switch_pkg::port_word_t d_in_nw, d_in_n, d_in_e, d_in_s, d_in_w;
  switch_pkg::port_word_t d_out_nw, d_out_n, d_out_ne, d_out_e;
  switch_pkg::port_word_t d_out_se, d_out_s, d_out_sw, d_out_w;
  logic c_out_nw, c_out_n, c_out_e, c_out_s, c_out_w;
  logic c_in_nw, c_in_n, c_in_ne, c_in_e, c_in_se, c_in_s, c_in_sw, c_in_w;

  switch_pkg::port_word_t [4:0] din_v;
  switch_pkg::port_word_t [7:0] dout_v;
  logic [4:0]  cout_v;
  logic [7:0]  cin_v;

  integer      seed = 16905;
  int          quota [5];      // words each input sends in this test
  logic [31:0] cur_cfg;        // routes the DUT is expected to hold
  logic [31:0] conf_word;
  int          conf_req;
  int          conf_ack;
  logic [7:0]  stall;
  int          sent [5];
  int          up_cred [5];
  int          cout_cnt [5];
  int          join_cnt [5];
  int          cyc;
  int          due_q [8][$];   // cycle at which each sink frees a slot
  logic [31:0] exp_q [8][$];
  int          rx_cnt [8];
  int          cmp_err;
  int          chk_err;
  int          n_tests;
  int          n_failed;
  string       in_name [5]  = '{"nw", "n", "e", "s", "w"};
  string       out_name [8] = '{"nw", "n", "ne", "e", "se", "s", "sw", "w"};

  `include "switch_ref.svh"

  assign {d_in_w, d_in_s, d_in_e, d_in_n, d_in_nw} = din_v;
  assign dout_v = {d_out_w, d_out_sw, d_out_s, d_out_se, d_out_e, d_out_ne, d_out_n, d_out_nw};
  assign cout_v = {c_out_w, c_out_s, c_out_e, c_out_n, c_out_nw};
  assign {c_in_w, c_in_sw, c_in_s, c_in_se, c_in_e, c_in_ne, c_in_n, c_in_nw} = cin_v;

  switch_top #(.buf_depth(buf_depth)) switch_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // upstream senders, sinks and config loading, all on the falling edge
  //////////////////////////////////////////////////////////////////////

  initial begin
    din_v    = '0;
    cin_v    = '0;
    conf_en  = 1'b0;
    conf_ack = 0;
    cyc      = 0;
    forever begin
      @(negedge clk);
      cyc++;
      din_v   = '0;
      conf_en = 1'b0;
      if (!rst_n) begin
        cin_v = '0;
        for (int i = 0; i < 5; i++) begin
          sent[i]     = 0;
          up_cred[i]  = buf_depth;
          cout_cnt[i] = 0;
          join_cnt[i] = 0;
        end
        for (int k = 0; k < 8; k++) begin
          due_q[k].delete();
        end
      end else begin
        for (int k = 0; k < 8; k++) begin
          if (dout_v[k].flit.valid) begin
            due_q[k].push_back(cyc + 3);   // sink latency
          end
          cin_v[k] = 1'b0;
          if (!stall[k] && due_q[k].size() > 0 && due_q[k][0] <= cyc) begin
            void'(due_q[k].pop_front());
            cin_v[k] = 1'b1;
          end
        end
        for (int i = 0; i < 5; i++) begin
          if (cout_v[i]) begin
            up_cred[i]++;
            cout_cnt[i]++;
          end
          if (credit_join(cur_cfg, i, cin_v)) begin
            join_cnt[i]++;
          end
        end
        if (conf_req != conf_ack) begin
          conf_en             = 1'b1;
          din_v[4].conf.sel   = conf_word;
          din_v[4].conf.valid = 1'b1;
          for (int i = 0; i < 4; i++) begin
            din_v[i].flit.data  = $random(seed);   // offered while loading, must vanish
            din_v[i].flit.valid = 1'b1;
          end
          conf_ack++;
        end else begin
          for (int i = 0; i < 5; i++) begin
            if (sent[i] < quota[i] && up_cred[i] > 0) begin
              din_v[i].flit.data  = $random(seed);
              din_v[i].flit.valid = 1'b1;
              up_cred[i]--;
              sent[i]++;
              for (int k = 0; k < 8; k++) begin
                if (expected_source(cur_cfg, k) == i) begin
                  exp_q[k].push_back(din_v[i].flit.data);
                end
              end
            end
          end
        end
      end
    end
  end

  // compare every output against the words its source sent
  always @(negedge clk) begin
    logic [31:0] want;
    if (!rst_n) begin
      for (int k = 0; k < 8; k++) begin
        exp_q[k].delete();
        rx_cnt[k] = 0;
      end
    end else begin
      for (int k = 0; k < 8; k++) begin
        if (dout_v[k].flit.valid) begin
          rx_cnt[k]++;
          if (exp_q[k].size() == 0) begin
            $display("unexpected word %h on output %s", dout_v[k].flit.data, out_name[k]);
            cmp_err++;
          end else begin
            want = exp_q[k].pop_front();
            if (dout_v[k].flit.data !== want) begin
              $display("Mismatch d_out_%s.data: expected %h, got %h",
                       out_name[k], want, dout_v[k].flit.data);
              cmp_err++;
            end
          end
        end else if (dout_v[k] !== '0) begin
          $display("Mismatch d_out_%s: expected %h, got %h", out_name[k], 33'h0, dout_v[k]);
          cmp_err++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequence helpers
  //////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    foreach (quota[i]) quota[i] = 0;
    stall   = '0;
    cur_cfg = '0;
    rst_n   = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic load_config(input logic [31:0] word);
    conf_word = word;
    conf_req += 2;   // two cycles of conf_en, the last one wins
    wait (conf_ack == conf_req);
    @(negedge clk);
    cur_cfg = word;
  endtask

  function automatic bit idle(input logic [4:0] skip);
    for (int i = 0; i < 5; i++) begin
      if (!skip[i] && (sent[i] < quota[i] || up_cred[i] != buf_depth)) return 1'b0;
    end
    for (int k = 0; k < 8; k++) begin
      if (exp_q[k].size() != 0 || due_q[k].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic wait_idle(input logic [4:0] skip);
    int quiet;
    quiet = 0;
    for (int n = 0; n < 2000 && quiet < 4; n++) begin
      @(negedge clk);
      quiet = idle(skip) ? quiet + 1 : 0;
    end
    if (quiet < 4) begin
      $display("traffic did not drain, words are missing or stuck");
      chk_err++;
    end
  endtask

  // one c_out and one joined credit per word sent
  task automatic check_counts(input logic [4:0] skip);
    for (int i = 0; i < 5; i++) begin
      if (!skip[i] && cout_cnt[i] != sent[i]) begin
        $display("Mismatch c_out_%s count: expected %h, got %h", in_name[i], sent[i], cout_cnt[i]);
        chk_err++;
      end
      if (!skip[i] && join_cnt[i] != sent[i]) begin
        $display("input %s got %0d joined credits for %0d words", in_name[i], join_cnt[i], sent[i]);
        chk_err++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    int errs;
    errs = chk_err + cmp_err - err_before;
    n_tests++;
    if (errs == 0) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errs);
      n_failed++;
    end
  endtask

  initial begin
    int e0;
    int snap;
    apply_reset();
    e0 = chk_err + cmp_err;
    repeat (20) @(negedge clk);
    check_counts('0);   // nothing sent, so no c_out either
    finish_test("reset state", e0);

    e0 = chk_err + cmp_err;
    apply_reset();
    load_config(32'h2040_5031);   // nw>nw n>n w>e s>s e>w
    foreach (quota[i]) quota[i] = n_uni;
    wait_idle('0);
    check_counts('0);
    finish_test("unicast", e0);

    e0 = chk_err + cmp_err;
    apply_reset();
    load_config(32'h0330_0330);   // n feeds n ne s sw
    quota[1] = n_multi;
    wait_idle('0);
    check_counts('0);
    finish_test("multicast", e0);

    e0 = chk_err + cmp_err;
    apply_reset();
    load_config(32'hA942_5F36);   // nw left unselected, codes 6 9 A F are off
    foreach (quota[i]) quota[i] = n_unr;
    wait_idle(5'b00001);
    repeat (30) @(negedge clk);
    if (cout_cnt[0] != buf_depth) begin
      $display("Mismatch c_out_nw count: expected %h, got %h", buf_depth, cout_cnt[0]);
      chk_err++;
    end
    check_counts(5'b00001);
    finish_test("unrouted input", e0);

    e0 = chk_err + cmp_err;
    apply_reset();
    load_config(32'h0000_5000);   // w>e only
    stall[3] = 1'b1;
    quota[4] = n_bp;
    repeat (40) @(negedge clk);
    snap = cout_cnt[4];
    if (rx_cnt[3] > buf_depth) begin
      $display("stalled output e delivered %0d words", rx_cnt[3]);
      chk_err++;
    end
    repeat (20) @(negedge clk);
    if (cout_cnt[4] != snap) begin
      $display("c_out_w kept pulsing while its sink was stalled");
      chk_err++;
    end
    stall[3] = 1'b0;
    wait_idle('0);
    check_counts('0);
    finish_test("back-pressure", e0);

    e0 = chk_err + cmp_err;
    apply_reset();
    load_config(32'h0000_5010);   // nw>n w>e
    quota[0] = n_reconf;
    quota[4] = n_reconf;
    wait_idle('0);
    load_config(32'h4101_0005);   // nw>se,sw w>nw s>w
    quota[0] += n_reconf;
    quota[4] += n_reconf;
    quota[3] = n_reconf;
    wait_idle('0);
    check_counts('0);
    finish_test("reconfiguration", e0);

    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, chk_err + cmp_err);
    if (chk_err + cmp_err == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the run stopped making progress", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tests
rtl/switch_pkg.sv
rtl/route_config.sv
rtl/input_stage.sv
rtl/crossbar.sv
rtl/switch_top.sv
tests/switch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the switch testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module switch_tb || exit 1
out=$(./obj_dir/Vswitch_tb)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }
